// ==== logic/mul_stream_params.svh ====
// Widths and CSR map of the multiply streamer; CSR addresses are word indices, not bytes
`ifndef MUL_STREAM_PARAMS_SVH
`define MUL_STREAM_PARAMS_SVH

// ------------------------------------------------
// Data path widths
// ------------------------------------------------
// Stream and TCDM word, two 32-bit operands
`define MS_DATA_WIDTH 64
// Byte address on the TCDM port
`define MS_TCDM_ADDR_WIDTH 20
// CSR data and address
`define MS_REG_WIDTH 32

// ------------------------------------------------
// CSR map
// ------------------------------------------------
// Addresses below this belong to the streamer
`define MS_STREAMER_CSR_NUM 4
`define MS_NUM_RW_CSR 2
`define MS_NUM_RO_CSR 2
// Address stride between memory words
`define MS_WORD_BYTES 8

`endif

// ==== logic/mul_stream_pkg.sv ====
// Shared types; widths follow mul_stream_params.svh, word counts are limited to 16 bits
`default_nettype none
`include "mul_stream_params.svh"

package mul_stream_pkg;

  // ------------------------------------------------
  // Plain vectors
  // ------------------------------------------------
  typedef logic [`MS_REG_WIDTH-1:0]       reg_data_t;
  typedef logic [`MS_REG_WIDTH-1:0]       reg_addr_t;
  typedef logic [`MS_TCDM_ADDR_WIDTH-1:0] tcdm_addr_t;
  // Operand a in the low half, b in the high half
  typedef logic [`MS_DATA_WIDTH-1:0]      stream_word_t;
  typedef logic [15:0]                    word_count_t;

  // ------------------------------------------------
  // CSR bus
  // ------------------------------------------------
  typedef struct packed {
    reg_addr_t addr;
    reg_data_t data;
    logic      write;
  } csr_req_t;

  // Writes answer with zero
  typedef struct packed {
    reg_data_t data;
  } csr_rsp_t;

  // ------------------------------------------------
  // TCDM port
  // ------------------------------------------------
  typedef struct packed {
    tcdm_addr_t   addr;
    logic         write;
    stream_word_t wdata;
    logic         valid;
  } tcdm_req_t;

  // rvalid comes one cycle after the read grant
  typedef struct packed {
    logic         gnt;
    stream_word_t rdata;
    logic         rvalid;
  } tcdm_rsp_t;

  // FSM states
  typedef enum logic {ACC_IDLE, ACC_RUN} accel_state_e;
  typedef enum logic {STR_IDLE, STR_RUN} streamer_state_e;

endpackage

`default_nettype wire

// ==== logic/csr_demux.sv ====
// One CSR transaction in flight at a time; downstream blocks must answer every request once
`timescale 1ns/100ps
`default_nettype none
`include "mul_stream_params.svh"

module csr_demux (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  // Core side
  input  mul_stream_pkg::csr_req_t csr_req_i,
  input  logic                     csr_req_valid_i,
  output logic                     csr_req_ready_o,
  output mul_stream_pkg::csr_rsp_t csr_rsp_o,
  output logic                     csr_rsp_valid_o,
  input  logic                     csr_rsp_ready_i,
  // Streamer side
  output mul_stream_pkg::csr_req_t str_req_o,
  output logic                     str_req_valid_o,
  input  logic                     str_req_ready_i,
  input  mul_stream_pkg::csr_rsp_t str_rsp_i,
  input  logic                     str_rsp_valid_i,
  output logic                     str_rsp_ready_o,
  // Manager side
  output mul_stream_pkg::csr_req_t mgr_req_o,
  output logic                     mgr_req_valid_o,
  input  logic                     mgr_req_ready_i,
  input  mul_stream_pkg::csr_rsp_t mgr_rsp_i,
  input  logic                     mgr_rsp_valid_i,
  output logic                     mgr_rsp_ready_o
);
  import mul_stream_pkg::*;

  logic sel_mgr;
  logic open_q;     // Free for a new request, low right after reset
  logic pend_q;     // Response still owed to the core
  logic own_mgr_q;  // Manager owns the pending response
  logic req_fire;
  logic rsp_fire;

  // ------------------------------------------------
  // Request routing
  // ------------------------------------------------
  assign sel_mgr = (csr_req_i.addr >= reg_addr_t'(`MS_STREAMER_CSR_NUM));

  // Streamer sees the address unchanged
  assign str_req_o = csr_req_i;

  // Manager addresses rebased to zero
  always_comb begin
    mgr_req_o      = csr_req_i;
    mgr_req_o.addr = csr_req_i.addr - reg_addr_t'(`MS_STREAMER_CSR_NUM);
  end

  assign str_req_valid_o = csr_req_valid_i & open_q & ~sel_mgr;
  assign mgr_req_valid_o = csr_req_valid_i & open_q & sel_mgr;
  assign csr_req_ready_o = open_q & (sel_mgr ? mgr_req_ready_i : str_req_ready_i);
  assign req_fire        = csr_req_valid_i & csr_req_ready_o;

  // ------------------------------------------------
  // Response return
  // ------------------------------------------------
  assign csr_rsp_o       = own_mgr_q ? mgr_rsp_i : str_rsp_i;
  assign csr_rsp_valid_o = pend_q & (own_mgr_q ? mgr_rsp_valid_i : str_rsp_valid_i);
  assign str_rsp_ready_o = pend_q & ~own_mgr_q & csr_rsp_ready_i;
  assign mgr_rsp_ready_o = pend_q & own_mgr_q & csr_rsp_ready_i;
  assign rsp_fire        = csr_rsp_valid_o & csr_rsp_ready_i;

  // Ownership tracking
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pend_q    <= 1'b0;
      own_mgr_q <= 1'b0;
      open_q    <= 1'b0;
    end else begin
      if (req_fire) begin
        pend_q    <= 1'b1;
        own_mgr_q <= sel_mgr;
      end else if (rsp_fire) begin
        pend_q <= 1'b0;
      end
      // Reopen only once the owed response has gone out
      open_q <= ~req_fire & (~pend_q | rsp_fire);
    end
  end

endmodule

`default_nettype wire

// ==== logic/csr_manager.sv ====
// Accelerator CSRs at rebased addresses 0..3; a start write stalls until the accelerator is idle
`timescale 1ns/100ps
`default_nettype none
`include "mul_stream_params.svh"

module csr_manager (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  // CSR port from the demux
  input  mul_stream_pkg::csr_req_t    req_i,
  input  logic                        req_valid_i,
  output logic                        req_ready_o,
  output mul_stream_pkg::csr_rsp_t    rsp_o,
  output logic                        rsp_valid_o,
  input  logic                        rsp_ready_i,
  // Register set toward the accelerator
  output mul_stream_pkg::word_count_t rw_count_o,
  output logic                        set_valid_o,
  input  logic                        set_ready_i,
  // Read-only status
  input  logic                        busy_i,
  input  mul_stream_pkg::word_count_t done_count_i
);
  import mul_stream_pkg::*;

  localparam int unsigned CsrCount = 0;
  localparam int unsigned CsrStart = 1;

  reg_data_t rw_q [`MS_NUM_RW_CSR];
  reg_data_t ro_set [`MS_NUM_RO_CSR];
  reg_data_t rsp_data_q;
  reg_addr_t ro_addr;
  logic      rsp_valid_q;
  logic      start_wr;
  logic      req_fire;

  // ------------------------------------------------
  // Start handshake
  // ------------------------------------------------
  assign start_wr    = req_i.write & (req_i.addr == reg_addr_t'(CsrStart));
  // Start write waits here while the accelerator runs
  assign set_valid_o = req_valid_i & start_wr & ~rsp_valid_q;
  assign req_ready_o = ~rsp_valid_q & (~start_wr | set_ready_i);
  assign req_fire    = req_valid_i & req_ready_o;
  assign rw_count_o  = word_count_t'(rw_q[CsrCount]);

  // Read-only set, busy first
  assign ro_set[0] = reg_data_t'(busy_i);
  assign ro_set[1] = reg_data_t'(done_count_i);
  assign ro_addr   = req_i.addr - reg_addr_t'(`MS_NUM_RW_CSR);

  // Read-write registers
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < `MS_NUM_RW_CSR; i++) begin
        rw_q[i] <= '0;
      end
    end else if (req_fire && req_i.write && req_i.addr < reg_addr_t'(`MS_NUM_RW_CSR)) begin
      rw_q[req_i.addr] <= req_i.data;
    end
  end

  // ------------------------------------------------
  // Registered response
  // ------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rsp_valid_q <= 1'b0;
    end else if (req_fire) begin
      rsp_valid_q <= 1'b1;
    end else if (rsp_ready_i) begin
      rsp_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      if (req_i.write) begin
        rsp_data_q <= '0;
      end else if (req_i.addr < reg_addr_t'(`MS_NUM_RW_CSR)) begin
        rsp_data_q <= rw_q[req_i.addr];
      end else if (ro_addr < reg_addr_t'(`MS_NUM_RO_CSR)) begin
        rsp_data_q <= ro_set[ro_addr];
      end else begin
        // Unmapped reads as zero
        rsp_data_q <= '0;
      end
    end
  end

  assign rsp_o.data  = rsp_data_q;
  assign rsp_valid_o = rsp_valid_q;

endmodule

`default_nettype wire

// ==== logic/mul_accel.sv ====
// Unsigned 32x32 multiplier, one word per cycle; accepts no more inputs than the latched count
`timescale 1ns/100ps
`default_nettype none
`include "mul_stream_params.svh"

module mul_accel (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  // Register set from the CSR manager
  input  mul_stream_pkg::word_count_t  count_i,
  input  logic                         set_valid_i,
  output logic                         set_ready_o,
  // Operand stream
  input  mul_stream_pkg::stream_word_t in_data_i,
  input  logic                         in_valid_i,
  output logic                         in_ready_o,
  // Product stream
  output mul_stream_pkg::stream_word_t out_data_o,
  output logic                         out_valid_o,
  input  logic                         out_ready_i,
  // Status
  output logic                         busy_o,
  output mul_stream_pkg::word_count_t  done_count_o
);
  import mul_stream_pkg::*;

  localparam int unsigned HalfWidth = `MS_DATA_WIDTH / 2;

  accel_state_e state_q;
  word_count_t  count_q;    // Words in this run
  word_count_t  in_cnt_q;   // Operands taken
  word_count_t  out_cnt_q;  // Products handed on
  stream_word_t prod_q;
  logic         out_valid_q;
  logic         in_fire;
  logic         out_fire;

  assign set_ready_o = (state_q == ACC_IDLE);
  // Stall input while the product register is stuck
  assign in_ready_o  = (state_q == ACC_RUN) & (in_cnt_q != count_q) &
                       (~out_valid_q | out_ready_i);
  assign in_fire     = in_valid_i & in_ready_o;
  assign out_fire    = out_valid_q & out_ready_i;

  assign out_data_o   = prod_q;
  assign out_valid_o  = out_valid_q;
  assign busy_o       = (state_q == ACC_RUN);
  assign done_count_o = out_cnt_q;

  // Product register
  always_ff @(posedge clk_i) begin
    if (in_fire) begin
      prod_q <= stream_word_t'(in_data_i[HalfWidth-1:0]) *
                stream_word_t'(in_data_i[`MS_DATA_WIDTH-1:HalfWidth]);
    end
  end

  // ------------------------------------------------
  // Run control
  // ------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q     <= ACC_IDLE;
      count_q     <= '0;
      in_cnt_q    <= '0;
      out_cnt_q   <= '0;
      out_valid_q <= 1'b0;
    end else begin
      if (in_fire) begin
        out_valid_q <= 1'b1;
      end else if (out_fire) begin
        out_valid_q <= 1'b0;
      end
      case (state_q)
        ACC_IDLE: begin
          if (set_valid_i) begin
            count_q   <= count_i;
            in_cnt_q  <= '0;
            out_cnt_q <= '0;
            // Zero count finishes at once
            if (count_i != '0) begin
              state_q <= ACC_RUN;
            end
          end
        end
        default: begin
          if (in_fire) begin
            in_cnt_q <= in_cnt_q + 1'b1;
          end
          if (out_fire) begin
            out_cnt_q <= out_cnt_q + 1'b1;
            if (word_count_t'(out_cnt_q + 1'b1) == count_q) begin
              state_q <= ACC_IDLE;
            end
          end
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== logic/tcdm_streamer.sv ====
// One reader and one writer on a single TCDM port; one read outstanding, writes win the port
`timescale 1ns/100ps
`default_nettype none
`include "mul_stream_params.svh"

module tcdm_streamer (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  // CSR port from the demux
  input  mul_stream_pkg::csr_req_t     req_i,
  input  logic                         req_valid_i,
  output logic                         req_ready_o,
  output mul_stream_pkg::csr_rsp_t     rsp_o,
  output logic                         rsp_valid_o,
  input  logic                         rsp_ready_i,
  // Read stream toward the accelerator
  output mul_stream_pkg::stream_word_t rd_data_o,
  output logic                         rd_valid_o,
  input  logic                         rd_ready_i,
  // Write stream from the accelerator
  input  mul_stream_pkg::stream_word_t wr_data_i,
  input  logic                         wr_valid_i,
  output logic                         wr_ready_o,
  // TCDM port
  output mul_stream_pkg::tcdm_req_t    tcdm_req_o,
  input  mul_stream_pkg::tcdm_rsp_t    tcdm_rsp_i
);
  import mul_stream_pkg::*;

  // CSR indices, the last address is start on write and busy on read
  localparam int unsigned CsrRdBase = 0;
  localparam int unsigned CsrWrBase = 1;
  localparam int unsigned CsrCount  = 2;
  localparam int unsigned NumCfgCsr = `MS_STREAMER_CSR_NUM - 1;

  reg_data_t       csr_q [NumCfgCsr];
  reg_data_t       rsp_data_q;
  logic            rsp_valid_q;
  logic            req_fire;
  logic            start;
  streamer_state_e state_q;
  word_count_t     count;
  word_count_t     rd_idx_q;
  word_count_t     wr_idx_q;
  tcdm_addr_t      rd_addr;
  tcdm_addr_t      wr_addr;
  logic            rd_pend_q;   // Read granted, data due next cycle
  logic            buf_valid_q;
  stream_word_t    buf_data_q;
  logic            rd_want;
  logic            wr_want;
  logic            rd_fire;
  logic            wr_fire;

  // ------------------------------------------------
  // CSR access
  // ------------------------------------------------
  assign req_ready_o = ~rsp_valid_q;
  assign req_fire    = req_valid_i & req_ready_o;
  // Start while running is dropped
  assign start = req_fire & req_i.write & (req_i.addr == reg_addr_t'(NumCfgCsr)) &
                 (state_q == STR_IDLE);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < NumCfgCsr; i++) begin
        csr_q[i] <= '0;
      end
      rsp_valid_q <= 1'b0;
    end else begin
      if (req_fire && req_i.write && req_i.addr < reg_addr_t'(NumCfgCsr)) begin
        csr_q[req_i.addr] <= req_i.data;
      end
      if (req_fire) begin
        rsp_valid_q <= 1'b1;
      end else if (rsp_ready_i) begin
        rsp_valid_q <= 1'b0;
      end
    end
  end

  // Read data, busy on the start address
  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      if (req_i.write) begin
        rsp_data_q <= '0;
      end else if (req_i.addr < reg_addr_t'(NumCfgCsr)) begin
        rsp_data_q <= csr_q[req_i.addr];
      end else begin
        rsp_data_q <= reg_data_t'(state_q == STR_RUN);
      end
    end
  end

  assign rsp_o.data  = rsp_data_q;
  assign rsp_valid_o = rsp_valid_q;

  // ------------------------------------------------
  // Address generation and port arbitration
  // ------------------------------------------------
  assign count   = word_count_t'(csr_q[CsrCount]);
  assign rd_addr = tcdm_addr_t'(csr_q[CsrRdBase]) +
                   tcdm_addr_t'(rd_idx_q) * tcdm_addr_t'(`MS_WORD_BYTES);
  assign wr_addr = tcdm_addr_t'(csr_q[CsrWrBase]) +
                   tcdm_addr_t'(wr_idx_q) * tcdm_addr_t'(`MS_WORD_BYTES);

  assign wr_want = (state_q == STR_RUN) & wr_valid_i;
  // Read only into an empty buffer
  assign rd_want = (state_q == STR_RUN) & (rd_idx_q != count) & ~rd_pend_q & ~buf_valid_q;
  assign wr_fire = wr_want & tcdm_rsp_i.gnt;
  assign rd_fire = rd_want & ~wr_want & tcdm_rsp_i.gnt;

  always_comb begin
    tcdm_req_o.valid = wr_want | rd_want;
    tcdm_req_o.write = wr_want;
    tcdm_req_o.addr  = wr_want ? wr_addr : rd_addr;
    tcdm_req_o.wdata = wr_data_i;
  end

  assign wr_ready_o = (state_q == STR_RUN) & tcdm_rsp_i.gnt;
  assign rd_data_o  = buf_data_q;
  assign rd_valid_o = buf_valid_q;

  // One-word read buffer
  always_ff @(posedge clk_i) begin
    if (rd_pend_q && tcdm_rsp_i.rvalid) begin
      buf_data_q <= tcdm_rsp_i.rdata;
    end
  end

  // ------------------------------------------------
  // Run control
  // ------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q     <= STR_IDLE;
      rd_idx_q    <= '0;
      wr_idx_q    <= '0;
      rd_pend_q   <= 1'b0;
      buf_valid_q <= 1'b0;
    end else begin
      if (rd_fire) begin
        rd_pend_q <= 1'b1;
      end else if (tcdm_rsp_i.rvalid) begin
        rd_pend_q <= 1'b0;
      end
      if (rd_pend_q && tcdm_rsp_i.rvalid) begin
        buf_valid_q <= 1'b1;
      end else if (rd_ready_i) begin
        buf_valid_q <= 1'b0;
      end
      case (state_q)
        STR_IDLE: begin
          if (start && count != '0) begin
            state_q  <= STR_RUN;
            rd_idx_q <= '0;
            wr_idx_q <= '0;
          end
        end
        default: begin
          if (rd_fire) begin
            rd_idx_q <= rd_idx_q + 1'b1;
          end
          // Busy drops with the last write grant
          if (wr_fire) begin
            wr_idx_q <= wr_idx_q + 1'b1;
            if (word_count_t'(wr_idx_q + 1'b1) == count) begin
              state_q <= STR_IDLE;
            end
          end
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== logic/mul_stream_top.sv ====
// Multiply streamer top level; single TCDM port, streamer and accelerator each need their own start
`timescale 1ns/100ps
`default_nettype none

module mul_stream_top (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  // CSR port from the core
  input  mul_stream_pkg::csr_req_t  csr_req_i,
  input  logic                      csr_req_valid_i,
  output logic                      csr_req_ready_o,
  output mul_stream_pkg::csr_rsp_t  csr_rsp_o,
  output logic                      csr_rsp_valid_o,
  input  logic                      csr_rsp_ready_i,
  // Shared memory port
  output mul_stream_pkg::tcdm_req_t tcdm_req_o,
  input  mul_stream_pkg::tcdm_rsp_t tcdm_rsp_i
);
  import mul_stream_pkg::*;

  // Demux to streamer
  csr_req_t     str_req;
  logic         str_req_valid;
  logic         str_req_ready;
  csr_rsp_t     str_rsp;
  logic         str_rsp_valid;
  logic         str_rsp_ready;
  // Demux to manager
  csr_req_t     mgr_req;
  logic         mgr_req_valid;
  logic         mgr_req_ready;
  csr_rsp_t     mgr_rsp;
  logic         mgr_rsp_valid;
  logic         mgr_rsp_ready;
  // Register set and status
  word_count_t  acc_count;
  logic         set_valid;
  logic         set_ready;
  logic         acc_busy;
  word_count_t  done_count;
  // Streams between streamer and accelerator
  stream_word_t stream2acc_data;
  logic         stream2acc_valid;
  logic         stream2acc_ready;
  stream_word_t acc2stream_data;
  logic         acc2stream_valid;
  logic         acc2stream_ready;

  // ------------------------------------------------
  // CSR split
  // ------------------------------------------------
  csr_demux i_csr_demux (
    .clk_i           ( clk_i           ),
    .rst_n_i         ( rst_n_i         ),
    .csr_req_i       ( csr_req_i       ),
    .csr_req_valid_i ( csr_req_valid_i ),
    .csr_req_ready_o ( csr_req_ready_o ),
    .csr_rsp_o       ( csr_rsp_o       ),
    .csr_rsp_valid_o ( csr_rsp_valid_o ),
    .csr_rsp_ready_i ( csr_rsp_ready_i ),
    .str_req_o       ( str_req         ),
    .str_req_valid_o ( str_req_valid   ),
    .str_req_ready_i ( str_req_ready   ),
    .str_rsp_i       ( str_rsp         ),
    .str_rsp_valid_i ( str_rsp_valid   ),
    .str_rsp_ready_o ( str_rsp_ready   ),
    .mgr_req_o       ( mgr_req         ),
    .mgr_req_valid_o ( mgr_req_valid   ),
    .mgr_req_ready_i ( mgr_req_ready   ),
    .mgr_rsp_i       ( mgr_rsp         ),
    .mgr_rsp_valid_i ( mgr_rsp_valid   ),
    .mgr_rsp_ready_o ( mgr_rsp_ready   )
  );

  // Accelerator CSRs
  csr_manager i_csr_manager (
    .clk_i        ( clk_i         ),
    .rst_n_i      ( rst_n_i       ),
    .req_i        ( mgr_req       ),
    .req_valid_i  ( mgr_req_valid ),
    .req_ready_o  ( mgr_req_ready ),
    .rsp_o        ( mgr_rsp       ),
    .rsp_valid_o  ( mgr_rsp_valid ),
    .rsp_ready_i  ( mgr_rsp_ready ),
    .rw_count_o   ( acc_count     ),
    .set_valid_o  ( set_valid     ),
    .set_ready_i  ( set_ready     ),
    .busy_i       ( acc_busy      ),
    .done_count_i ( done_count    )
  );

  // ------------------------------------------------
  // Data path
  // ------------------------------------------------
  mul_accel i_mul_accel (
    .clk_i        ( clk_i            ),
    .rst_n_i      ( rst_n_i          ),
    .count_i      ( acc_count        ),
    .set_valid_i  ( set_valid        ),
    .set_ready_o  ( set_ready        ),
    .in_data_i    ( stream2acc_data  ),
    .in_valid_i   ( stream2acc_valid ),
    .in_ready_o   ( stream2acc_ready ),
    .out_data_o   ( acc2stream_data  ),
    .out_valid_o  ( acc2stream_valid ),
    .out_ready_i  ( acc2stream_ready ),
    .busy_o       ( acc_busy         ),
    .done_count_o ( done_count       )
  );

  tcdm_streamer i_tcdm_streamer (
    .clk_i       ( clk_i            ),
    .rst_n_i     ( rst_n_i          ),
    .req_i       ( str_req          ),
    .req_valid_i ( str_req_valid    ),
    .req_ready_o ( str_req_ready    ),
    .rsp_o       ( str_rsp          ),
    .rsp_valid_o ( str_rsp_valid    ),
    .rsp_ready_i ( str_rsp_ready    ),
    .rd_data_o   ( stream2acc_data  ),
    .rd_valid_o  ( stream2acc_valid ),
    .rd_ready_i  ( stream2acc_ready ),
    .wr_data_i   ( acc2stream_data  ),
    .wr_valid_i  ( acc2stream_valid ),
    .wr_ready_o  ( acc2stream_ready ),
    .tcdm_req_o  ( tcdm_req_o       ),
    .tcdm_rsp_i  ( tcdm_rsp_i       )
  );

endmodule

`default_nettype wire

// ==== tests/tb_clock_gen.sv ====
// Free-running testbench clock; first rising edge comes half a period after time zero
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
  parameter int unsigned PeriodNs = 40
) (
  output logic clk_o
);

  // Toggle every half period
  initial begin
    clk_o = 1'b0;
    forever begin
      #(PeriodNs / 2) clk_o = ~clk_o;
    end
  end

endmodule

`default_nettype wire

// ==== tests/tb_mul_stream.sv ====
// Run from the project root; testdata holds NumWords words, the memory answers reads a cycle late
`timescale 1ns/100ps
`default_nettype none
`include "mul_stream_params.svh"

module tb_mul_stream;
  import mul_stream_pkg::*;

  localparam int unsigned NumWords   = 8;
  localparam int unsigned DataLen    = 3 + 2 * NumWords;
  localparam int unsigned JobsPerRun = 2;

  // Job settings from the first three testdata lines
  typedef struct packed {
    tcdm_addr_t  rd_base;
    tcdm_addr_t  wr_base;
    word_count_t count;
  } job_cfg_t;

  logic         clk;
  logic         rst_n;
  csr_req_t     csr_req;
  logic         csr_req_valid;
  logic         csr_req_ready;
  csr_rsp_t     csr_rsp;
  logic         csr_rsp_valid;
  logic         csr_rsp_ready;
  tcdm_req_t    tcdm_req;
  tcdm_rsp_t    tcdm_rsp;

  stream_word_t testdata [DataLen];
  stream_word_t mem [tcdm_addr_t];   // Sparse TCDM contents
  job_cfg_t     cfg;
  integer       seed = 52;
  logic         random_mode;         // Random gnt and rsp_ready when set
  logic         rd_granted;
  stream_word_t rd_word;
  int unsigned  cycle_cnt;
  int unsigned  cycle_limit;
  int unsigned  req_total;
  int unsigned  rsp_total;
  reg_addr_t    rw_addrs [4] = '{0, 1, 2, 4};

  tb_clock_gen #(.PeriodNs(40)) clk_gen_i (.clk_o(clk));

  mul_stream_top dut_i (
    .clk_i           ( clk           ),
    .rst_n_i         ( rst_n         ),
    .csr_req_i       ( csr_req       ),
    .csr_req_valid_i ( csr_req_valid ),
    .csr_req_ready_o ( csr_req_ready ),
    .csr_rsp_o       ( csr_rsp       ),
    .csr_rsp_valid_o ( csr_rsp_valid ),
    .csr_rsp_ready_i ( csr_rsp_ready ),
    .tcdm_req_o      ( tcdm_req      ),
    .tcdm_rsp_i      ( tcdm_rsp      )
  );

  // ------------------------------------------------
  // Failure reporting and value checks
  // ------------------------------------------------
  task automatic stop_on_failure();
    $display("Verification failed");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic expect_equal(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
    assert (actual === expected) else begin
      $display("** Error at %0t ns: %s expected 0x%0h, actual 0x%0h",
               $time, name, expected, actual);
      stop_on_failure();
    end
  endtask

  // Address-dependent pattern for readback
  function automatic reg_data_t rw_pattern(input reg_addr_t addr);
    return {8'hA5, addr[7:0], 8'h3C, ~addr[7:0]};
  endfunction

  // Missing words read as unknown so a lost write fails
  function automatic stream_word_t mem_word(input tcdm_addr_t addr);
    if (mem.exists(addr)) begin
      return mem[addr];
    end
    return 'x;
  endfunction

  // ------------------------------------------------
  // Memory model and back-pressure
  // ------------------------------------------------
  initial begin
    tcdm_rsp      = '0;
    csr_rsp_ready = 1'b0;
    rd_granted    = 1'b0;
    rd_word       = '0;
    forever begin
      @(posedge clk);
      #5;
      // Read data one cycle after its grant
      tcdm_rsp.rvalid = rd_granted;
      tcdm_rsp.rdata  = rd_word;
      if (random_mode) begin
        tcdm_rsp.gnt  = (($random(seed) & 3) != 0);
        csr_rsp_ready = $random(seed) & 1;
      end else begin
        tcdm_rsp.gnt  = 1'b1;
        csr_rsp_ready = 1'b1;
      end
      // Request is settled here and transfers at the next edge
      @(negedge clk);
      rd_granted = tcdm_req.valid & tcdm_rsp.gnt & ~tcdm_req.write;
      if (tcdm_req.valid && tcdm_rsp.gnt) begin
        if (tcdm_req.write) begin
          mem[tcdm_req.addr] = tcdm_req.wdata;
        end else begin
          rd_word = mem.exists(tcdm_req.addr) ? mem[tcdm_req.addr] : '0;
        end
      end
    end
  end

  // Each CSR response must belong to an accepted request
  always @(negedge clk) begin
    if (csr_req_valid && csr_req_ready) begin
      req_total++;
    end
    if (csr_rsp_valid && csr_rsp_ready) begin
      rsp_total++;
      assert (rsp_total <= req_total) else begin
        $display("A CSR response arrived at %0t ns with no request open", $time);
        stop_on_failure();
      end
    end
  end

  // Run length limit
  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > cycle_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      stop_on_failure();
    end
  end

  // ------------------------------------------------
  // CSR driver
  // ------------------------------------------------
  task automatic csr_transfer(input reg_addr_t addr, input reg_data_t wdata,
                              input logic write, output reg_data_t rdata);
    logic done;
    done = 1'b0;
    @(posedge clk);
    #5;
    csr_req.addr  = addr;
    csr_req.data  = wdata;
    csr_req.write = write;
    csr_req_valid = 1'b1;
    while (!done) begin
      @(negedge clk);
      done = csr_req_ready;
    end
    @(posedge clk);
    #5;
    csr_req_valid = 1'b0;
    done          = 1'b0;
    while (!done) begin
      @(negedge clk);
      done = csr_rsp_valid & csr_rsp_ready;
    end
    rdata = csr_rsp.data;
  endtask

  // Writes answer with zero
  task automatic write_csr(input reg_addr_t addr, input reg_data_t wdata);
    reg_data_t rdata;
    csr_transfer(addr, wdata, 1'b1, rdata);
    expect_equal($sformatf("csr_rsp_o.data (write CSR %0d)", addr), '0, rdata);
  endtask

  task automatic read_csr(input reg_addr_t addr, output reg_data_t rdata);
    csr_transfer(addr, '0, 1'b0, rdata);
  endtask

  task automatic check_csr(input reg_addr_t addr, input reg_data_t expected);
    reg_data_t rdata;
    read_csr(addr, rdata);
    expect_equal($sformatf("csr_rsp_o.data (CSR %0d)", addr), expected, rdata);
  endtask

  // Done when both busy flags read zero
  task automatic wait_until_idle();
    reg_data_t str_busy;
    reg_data_t acc_busy;
    str_busy = 1;
    acc_busy = 1;
    while (str_busy != 0 || acc_busy != 0) begin
      read_csr(3, str_busy);
      read_csr(6, acc_busy);
    end
  endtask

  // ------------------------------------------------
  // One multiply job
  // ------------------------------------------------
  task automatic run_job();
    tcdm_addr_t addr;
    // Fresh operands and an empty result buffer
    for (int i = 0; i < cfg.count; i++) begin
      mem[cfg.rd_base + tcdm_addr_t'(i * `MS_WORD_BYTES)] = testdata[3 + i];
      addr = cfg.wr_base + tcdm_addr_t'(i * `MS_WORD_BYTES);
      if (mem.exists(addr)) begin
        mem.delete(addr);
      end
    end
    write_csr(0, reg_data_t'(cfg.rd_base));
    write_csr(1, reg_data_t'(cfg.wr_base));
    write_csr(2, reg_data_t'(cfg.count));
    write_csr(4, reg_data_t'(cfg.count));
    // Streamer starts before the accelerator
    write_csr(3, 1);
    write_csr(5, 1);
    wait_until_idle();
    check_csr(7, reg_data_t'(cfg.count));
    for (int i = 0; i < cfg.count; i++) begin
      addr = cfg.wr_base + tcdm_addr_t'(i * `MS_WORD_BYTES);
      expect_equal($sformatf("tcdm_req_o.wdata at 0x%05h", addr),
                   testdata[3 + cfg.count + i], mem_word(addr));
    end
  endtask

  // ------------------------------------------------
  // Test sequence
  // ------------------------------------------------
  initial begin
    cycle_cnt     = 0;
    req_total     = 0;
    rsp_total     = 0;
    random_mode   = 1'b0;
    rst_n         = 1'b0;
    csr_req       = '0;
    csr_req_valid = 1'b0;
    $readmemh("tests/mul_stream_testdata.txt", testdata);
    cfg.rd_base = tcdm_addr_t'(testdata[0]);
    cfg.wr_base = tcdm_addr_t'(testdata[1]);
    cfg.count   = word_count_t'(testdata[2]);
    cycle_limit = 200 * JobsPerRun * int'(cfg.count) + 500;

    repeat (7) @(posedge clk);
    // Handshake outputs stay low in reset
    @(negedge clk);
    expect_equal("csr_req_ready_o", 1'b0, csr_req_ready);
    expect_equal("csr_rsp_valid_o", 1'b0, csr_rsp_valid);
    expect_equal("tcdm_req_o.valid", 1'b0, tcdm_req.valid);
    @(posedge clk);
    #5;
    rst_n = 1'b1;
    expect_equal("testdata word count", NumWords, cfg.count);

    // Read-write CSR readback
    foreach (rw_addrs[i]) begin
      write_csr(rw_addrs[i], rw_pattern(rw_addrs[i]));
    end
    foreach (rw_addrs[i]) begin
      check_csr(rw_addrs[i], rw_pattern(rw_addrs[i]));
    end

    // Unmapped addresses read zero and touch nothing
    write_csr(8, '1);
    write_csr(32'h40, '1);
    check_csr(8, '0);
    check_csr(32'h40, '0);
    foreach (rw_addrs[i]) begin
      check_csr(rw_addrs[i], rw_pattern(rw_addrs[i]));
    end

    // Full handshakes first and random gnt and rsp_ready after
    run_job();
    @(negedge clk);
    random_mode = 1'b1;
    run_job();

    // Let the last response be counted first
    @(posedge clk);
    expect_equal("CSR response count", req_total, rsp_total);
    $display("Verification passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tests/mul_stream_testdata.txt ====
// Lines 1-3: read base, write base, word count
// Then count operand words {b, a}, then count expected products a*b
0000000000001000
0000000000002000
0000000000000008
// Operands, a in the low half, b in the high half
00000005_00000003
FFFFFFFF_FFFFFFFF
00010000_00010000
00000010_12345678
00000002_80000000
DEADBEEF_00000000
0000FFFF_0000FFFF
00000002_FFFFFFFF
// Expected products
00000000_0000000F
FFFFFFFE_00000001
00000001_00000000
00000001_23456780
00000001_00000000
00000000_00000000
00000000_FFFE0001
00000001_FFFFFFFE

// ==== verilog.f ====
+incdir+logic
logic/mul_stream_pkg.sv
logic/csr_demux.sv
logic/csr_manager.sv
logic/mul_accel.sv
logic/tcdm_streamer.sv
logic/mul_stream_top.sv
tests/tb_clock_gen.sv
tests/tb_mul_stream.sv

// ==== Bender.yml ====
package:
  name: mul_stream

sources:
  - include_dirs:
      - logic
    files:
      - logic/mul_stream_pkg.sv
      - logic/csr_demux.sv
      - logic/csr_manager.sv
      - logic/mul_accel.sv
      - logic/tcdm_streamer.sv
      - logic/mul_stream_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - tests/tb_clock_gen.sv
      - tests/tb_mul_stream.sv
